/* evt_router_top.f */
+incdir+verilog
verilog/evt_router_pkg.sv
verilog/evt_reg_bank.sv
verilog/pkt_assembler.sv
verilog/pkt_router.sv
verilog/evt_router_top.sv
verif/evt_router_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the event router testbench with Verilator.
# Exit status is 0 only when the log holds the pass message.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module evt_router_tb \
  -f evt_router_top.f \
  -o evt_router_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "build failed, see $BUILD_LOG"
  exit 1
fi

./obj_dir/evt_router_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$SIM_LOG"; then
  echo "simulation passed"
  exit 0
fi

echo "simulation failed, see $SIM_LOG"
exit 1

/* verif/evt_router_tb.sv */
// testbench for evt_router_top
// reference model applies the key mapping and first-match routing rules
// to the configuration written over APB, one expected-key queue per channel
// inputs change 1 ns after the rising edge and outputs are sampled on it
// every wait is bounded by its own cycle timeout

`timescale 1ns/10ps
`include "evt_router_defines.svh"

module evt_router_tb;

  localparam int TIMEOUT      = 200;
  localparam int MODE_ROUTE   = 0;
  localparam int MODE_DROP    = 1;
  localparam int MODE_DISCARD = 2;

  logic                            pl_clk0_buf_int;
  logic                            arst_n;
  logic                            psel;
  logic                            penable;
  logic                            pwrite;
  evt_router_pkg::apb_addr_t       paddr;
  evt_router_pkg::word_t           pwdata;
  evt_router_pkg::word_t           prdata;
  logic                            pready;
  logic                            pslverr;
  evt_router_pkg::evt_t            evt_data;
  logic                            evt_vld;
  logic                            evt_rdy;
  evt_router_pkg::pkt_t            ch_data [`NUM_CHANS - 1:0];
  logic [`NUM_CHANS - 1:0]         ch_vld;
  logic [`NUM_CHANS - 1:0]         ch_rdy;

  // model copy of the configuration
  evt_router_pkg::pkt_t            m_mp_key;
  evt_router_pkg::pkt_t            m_fmsk [`NUM_FIELDS];
  evt_router_pkg::sft_t            m_fsft [`NUM_FIELDS];
  evt_router_pkg::pkt_t            m_rt_key [`NUM_RREGS];
  evt_router_pkg::pkt_t            m_rt_mask [`NUM_RREGS];
  int                              m_rt_chan [`NUM_RREGS];

  // expected keys and delivered counts per channel
  evt_router_pkg::pkt_t            exp_q [`NUM_CHANS][$];
  int                              delivered [`NUM_CHANS];
  int                              exp_routed;
  int                              exp_dropped;

  string                           test_name;
  int                              err_cnt;
  int                              test_errs;
  int                              tests_ok;
  int                              tests_bad;
  int                              seed;

  evt_router_top u_dut (
    .pl_clk0_buf_int (pl_clk0_buf_int),
    .arst_n          (arst_n),
    .psel            (psel),
    .penable         (penable),
    .pwrite          (pwrite),
    .paddr           (paddr),
    .pwdata          (pwdata),
    .prdata          (prdata),
    .pready          (pready),
    .pslverr         (pslverr),
    .evt_data        (evt_data),
    .evt_vld         (evt_vld),
    .evt_rdy         (evt_rdy),
    .ch_data         (ch_data),
    .ch_vld          (ch_vld),
    .ch_rdy          (ch_rdy)
  );

  // 8 ns clock
  initial
  begin
    pl_clk0_buf_int = 1'b0;
    forever
      #4 pl_clk0_buf_int = ~pl_clk0_buf_int;
  end

  //--------------------------------------------------------------------
  // checking helpers
  //--------------------------------------------------------------------
  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
    else
    begin
      $display("Fail %s: %s expected %h actual %h", test_name, what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic timed_out(input string what);
    $display("error in %s: timed out waiting for %s", test_name, what);
    err_cnt++;
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errs = err_cnt;
  endtask

  task automatic end_test();
    if (err_cnt == test_errs)
    begin
      tests_ok++;
      $display("test %s: ok", test_name);
    end
    else
    begin
      tests_bad++;
      $display("test %s: %0d errors", test_name, err_cnt - test_errs);
    end
  endtask

  // watches the channel outputs against the model queues
  always @(posedge pl_clk0_buf_int)
  begin
    evt_router_pkg::pkt_t exp_key;
    if (arst_n)
    begin
      for (int c = 0; c < `NUM_CHANS; c++)
      begin
        if (ch_vld[c])
        begin
          assert (exp_q[c].size() != 0)
          else
          begin
            $display("error in %s: channel %0d valid with no packet expected", test_name, c);
            err_cnt++;
          end
          if (ch_rdy[c] && (exp_q[c].size() != 0))
          begin
            exp_key = exp_q[c].pop_front();
            delivered[c]++;
            check_value($sformatf("channel %0d key", c), exp_key, ch_data[c]);
          end
        end
      end
    end
  end

  //--------------------------------------------------------------------
  // reference model
  //--------------------------------------------------------------------
  function automatic evt_router_pkg::pkt_t map_key(input evt_router_pkg::evt_t evt);
    // base key OR the masked and right shifted fields
    return m_mp_key | ((evt & m_fmsk[0]) >> m_fsft[0]) | ((evt & m_fmsk[1]) >> m_fsft[1]);
  endfunction

  // lowest matching entry or -1 when nothing matches
  function automatic int route_chan(input evt_router_pkg::pkt_t key);
    for (int i = 0; i < `NUM_RREGS; i++)
      if ((key & m_rt_mask[i]) == m_rt_key[i])
        return m_rt_chan[i];
    return -1;
  endfunction

  function automatic int pending_count();
    int n;
    n = 0;
    for (int c = 0; c < `NUM_CHANS; c++)
      n += exp_q[c].size();
    return n;
  endfunction

  //--------------------------------------------------------------------
  // APB and event drivers start and end 1 ns after an edge
  //--------------------------------------------------------------------
  task automatic apb_xfer(input logic wr, input evt_router_pkg::apb_addr_t addr,
                          input evt_router_pkg::word_t wdata,
                          output evt_router_pkg::word_t rdata, output logic err);
    int n;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge pl_clk0_buf_int);
    #1;
    penable = 1'b1;
    @(posedge pl_clk0_buf_int);
    n = 1;
    while (!pready && (n < TIMEOUT))
    begin
      @(posedge pl_clk0_buf_int);
      n++;
    end
    assert (pready) else timed_out("pready");
    rdata = prdata;
    err   = pslverr;
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input evt_router_pkg::apb_addr_t addr,
                           input evt_router_pkg::word_t data, output logic err);
    evt_router_pkg::word_t unused;
    apb_xfer(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input evt_router_pkg::apb_addr_t addr,
                          output evt_router_pkg::word_t data, output logic err);
    apb_xfer(1'b0, addr, '0, data, err);
  endtask

  // accesses that must not raise pslverr
  task automatic cfg_write(input evt_router_pkg::apb_addr_t addr,
                           input evt_router_pkg::word_t data);
    logic err;
    apb_write(addr, data, err);
    check_value($sformatf("pslverr on write %h", addr), 1'b0, err);
  endtask

  task automatic reg_read(input evt_router_pkg::apb_addr_t addr,
                          output evt_router_pkg::word_t data);
    logic err;
    apb_read(addr, data, err);
    check_value($sformatf("pslverr on read %h", addr), 1'b0, err);
  endtask

  task automatic set_mapper(input evt_router_pkg::pkt_t key, input evt_router_pkg::pkt_t f0,
                            input int s0, input evt_router_pkg::pkt_t f1, input int s1);
    m_mp_key = key;
    m_fmsk[0] = f0;
    m_fmsk[1] = f1;
    m_fsft[0] = evt_router_pkg::sft_t'(s0);
    m_fsft[1] = evt_router_pkg::sft_t'(s1);
    cfg_write(`REG_MP_KEY, key);
    cfg_write(`REG_FMSK0, f0);
    cfg_write(`REG_FMSK1, f1);
    // shift 0 in bits 4..0, shift 1 in bits 12..8
    cfg_write(`REG_FSFT, ((s1 & 32'h1F) << 8) | (s0 & 32'h1F));
  endtask

  task automatic set_route(input int i, input evt_router_pkg::pkt_t key,
                           input evt_router_pkg::pkt_t mask, input int chan);
    m_rt_key[i]  = key;
    m_rt_mask[i] = mask;
    m_rt_chan[i] = chan;
    cfg_write(evt_router_pkg::apb_addr_t'(`REG_RT_KEY + `REG_RT_STRIDE * i), key);
    cfg_write(evt_router_pkg::apb_addr_t'(`REG_RT_MASK + `REG_RT_STRIDE * i), mask);
    cfg_write(evt_router_pkg::apb_addr_t'(`REG_RT_CHAN + `REG_RT_STRIDE * i), chan);
  endtask

  // mode says what the model expects from the event
  task automatic send_event(input evt_router_pkg::evt_t evt, input int mode);
    evt_router_pkg::pkt_t key;
    int ch;
    int n;
    key      = map_key(evt);
    ch       = route_chan(key);
    evt_data = evt;
    evt_vld  = 1'b1;
    @(posedge pl_clk0_buf_int);
    n = 1;
    while (!evt_rdy && (n < TIMEOUT))
    begin
      @(posedge pl_clk0_buf_int);
      n++;
    end
    assert (evt_rdy) else timed_out("evt_rdy");
    #1;
    evt_vld = 1'b0;
    if ((mode == MODE_ROUTE) && (ch >= 0))
    begin
      exp_q[ch].push_back(key);
      exp_routed++;
    end
    else if (mode != MODE_DISCARD)
      exp_dropped++;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while ((pending_count() != 0) && (n < TIMEOUT))
    begin
      @(posedge pl_clk0_buf_int);
      n++;
    end
    assert (pending_count() == 0) else timed_out("channel outputs to drain");
    @(posedge pl_clk0_buf_int);
    #1;
  endtask

  // polls a counter register until it reaches the target
  task automatic wait_counter(input evt_router_pkg::apb_addr_t addr,
                              input evt_router_pkg::word_t target, input string what);
    evt_router_pkg::word_t val;
    int n;
    n = 0;
    reg_read(addr, val);
    while ((val != target) && (n < TIMEOUT))
    begin
      reg_read(addr, val);
      n++;
    end
    assert (val == target) else timed_out(what);
  endtask

  // register map walk for the readback test
  function automatic evt_router_pkg::apb_addr_t cfg_addr(input int i);
    int bank;
    int entry;
    bank  = (i - 6) / `NUM_RREGS;
    entry = (i - 6) % `NUM_RREGS;
    case (i)
      0: return `REG_CTRL;
      1: return `REG_MP_KEY;
      2: return `REG_FMSK0;
      3: return `REG_FMSK1;
      4: return `REG_FSFT;
      5: return `REG_DROP_WAIT;
      default:
      begin
        if (bank == 0)
          return evt_router_pkg::apb_addr_t'(`REG_RT_KEY + `REG_RT_STRIDE * entry);
        else if (bank == 1)
          return evt_router_pkg::apb_addr_t'(`REG_RT_MASK + `REG_RT_STRIDE * entry);
        else
          return evt_router_pkg::apb_addr_t'(`REG_RT_CHAN + `REG_RT_STRIDE * entry);
      end
    endcase
  endfunction

  // implemented bits of each register
  function automatic evt_router_pkg::word_t cfg_mask(input int i);
    if (i == 0)
      return 32'h0000_0001;
    else if (i == 4)
      return 32'h0000_1F1F;
    else if (i == 5)
      return 32'h0000_FFFF;
    else if (i >= 6 + 2 * `NUM_RREGS)
      return 32'h0000_0001;
    return 32'hFFFF_FFFF;
  endfunction

  //--------------------------------------------------------------------
  // test sequence
  //--------------------------------------------------------------------
  initial
  begin
    evt_router_pkg::word_t wr_val [6 + 3 * `NUM_RREGS];
    evt_router_pkg::word_t rdata;
    evt_router_pkg::word_t r0;
    evt_router_pkg::word_t d0;
    evt_router_pkg::word_t r1;
    evt_router_pkg::word_t d1;
    logic                  err;

    seed        = 32'h1159;
    err_cnt     = 0;
    tests_ok    = 0;
    tests_bad   = 0;
    exp_routed  = 0;
    exp_dropped = 0;
    test_name   = "reset";
    for (int c = 0; c < `NUM_CHANS; c++)
      delivered[c] = 0;
    arst_n   = 1'b0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    evt_data = '0;
    evt_vld  = 1'b0;
    ch_rdy   = '1;
    repeat (2) @(posedge pl_clk0_buf_int);
    #1;
    arst_n = 1'b1;

    // 1. config readback plus read-only and unmapped errors
    begin_test("register_access");
    for (int i = 0; i < 6 + 3 * `NUM_RREGS; i++)
    begin
      wr_val[i] = $random(seed);
      cfg_write(cfg_addr(i), wr_val[i]);
    end
    for (int i = 0; i < 6 + 3 * `NUM_RREGS; i++)
    begin
      reg_read(cfg_addr(i), rdata);
      check_value($sformatf("readback %h", cfg_addr(i)), wr_val[i] & cfg_mask(i), rdata);
    end
    apb_write(`REG_CTR_ROUTED, 32'h1234_5678, err);
    check_value("pslverr on counter write", 1'b1, err);
    reg_read(`REG_CTR_ROUTED, rdata);
    check_value("routed counter after write", 32'h0, rdata);
    apb_write(8'h18, 32'hDEAD_BEEF, err);
    check_value("pslverr on unmapped write", 1'b1, err);
    end_test();

    // 2. random events where bit 0 of the key picks the channel
    begin_test("map_and_route");
    cfg_write(`REG_CTRL, 32'h0);
    set_mapper(32'hA500_0000, 32'h0000_00FF, 0, 32'h00FF_0000, 8);
    set_route(0, 32'hA500_0000, 32'hFF00_0001, 0);
    set_route(1, 32'hA500_0001, 32'hFF00_0001, 1);
    set_route(2, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 0);
    set_route(3, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 1);
    cfg_write(`REG_DROP_WAIT, 32'd100);
    cfg_write(`REG_CTRL, 32'h1);
    for (int i = 0; i < 24; i++)
      send_event($random(seed), MODE_ROUTE);
    wait_drain();
    reg_read(`REG_CTR_ROUTED, rdata);
    check_value("routed counter", exp_routed, rdata);
    reg_read(`REG_CTR_DROPPED, rdata);
    check_value("dropped counter", exp_dropped, rdata);
    end_test();

    // 3. entries 0 and 1 both match and entry 0 sends to channel 1
    begin_test("first_match");
    set_route(0, 32'hA500_0000, 32'hFF00_0000, 1);
    set_route(1, 32'hA500_0000, 32'hFF00_0001, 0);
    r0 = delivered[1];
    for (int i = 0; i < 8; i++)
      send_event($random(seed) & 32'hFFFF_FFFE, MODE_ROUTE);
    wait_drain();
    check_value("channel 1 packets", 8, delivered[1] - r0);
    end_test();

    // 4. top byte 5A hits no entry
    begin_test("no_match");
    set_mapper(32'h5A00_0000, 32'h0000_00FF, 0, 32'h00FF_0000, 8);
    for (int i = 0; i < 6; i++)
      send_event($random(seed), MODE_ROUTE);
    wait_counter(`REG_CTR_DROPPED, exp_dropped, "dropped counter");
    wait_drain();
    end_test();

    // 5. channel 0 stalled so the first packet is held and the rest time out
    begin_test("back_pressure");
    set_mapper(32'hA500_0000, 32'h0000_00FF, 0, 32'h00FF_0000, 8);
    set_route(0, 32'hA500_0000, 32'hFF00_0000, 0);
    cfg_write(`REG_DROP_WAIT, 32'd4);
    reg_read(`REG_CTR_ROUTED, r0);
    reg_read(`REG_CTR_DROPPED, d0);
    ch_rdy[0] = 1'b0;
    send_event($random(seed), MODE_ROUTE);
    for (int i = 0; i < 3; i++)
      send_event($random(seed), MODE_DROP);
    wait_counter(`REG_CTR_DROPPED, exp_dropped, "dropped counter");
    check_value("held ch_vld", 1'b1, ch_vld[0]);
    check_value("held key", exp_q[0][0], ch_data[0]);
    ch_rdy[0] = 1'b1;
    wait_drain();
    reg_read(`REG_CTR_ROUTED, r1);
    reg_read(`REG_CTR_DROPPED, d1);
    check_value("routed plus dropped", 4, (r1 - r0) + (d1 - d0));
    end_test();

    // 6. events absorbed and nothing counted while disabled
    begin_test("disable");
    cfg_write(`REG_CTRL, 32'h0);
    reg_read(`REG_CTR_ROUTED, r0);
    reg_read(`REG_CTR_DROPPED, d0);
    for (int i = 0; i < 6; i++)
      send_event($random(seed), MODE_DISCARD);
    // observation window for the monitor to flag any valid
    repeat (20) @(posedge pl_clk0_buf_int);
    #1;
    reg_read(`REG_CTR_ROUTED, r1);
    reg_read(`REG_CTR_DROPPED, d1);
    check_value("routed counter", r0, r1);
    check_value("dropped counter", d0, d1);
    end_test();

    $display("tests ok %0d, tests failed %0d, errors %0d", tests_ok, tests_bad, err_cnt);
    if (err_cnt == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

/* verilog/evt_reg_bank.sv */
// APB register bank of the event router
// pready is tied high, so every transfer is setup plus one access cycle
// pslverr flags unmapped addresses and writes to the two counters
// writes to a counter are ignored, counters wrap at 2^32

`timescale 1ns/10ps
`include "evt_router_defines.svh"

module evt_reg_bank
(
  input  logic                      pl_clk0_buf_int,
  input  logic                      arst_n,

  // APB slave
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  evt_router_pkg::apb_addr_t paddr,
  input  evt_router_pkg::word_t     pwdata,
  output evt_router_pkg::word_t     prdata,
  output logic                      pready,
  output logic                      pslverr,

  // counter pulses from the router
  input  logic                      routed_cnt,
  input  logic                      dropped_cnt,

  // configuration
  output logic                      enable,
  output evt_router_pkg::pkt_t      mp_key,
  output evt_router_pkg::pkt_t      fmsk [`NUM_FIELDS - 1:0],
  output evt_router_pkg::sft_t      fsft [`NUM_FIELDS - 1:0],
  output evt_router_pkg::wait_t     drop_wait,
  output evt_router_pkg::pkt_t      rt_key  [`NUM_RREGS - 1:0],
  output evt_router_pkg::pkt_t      rt_mask [`NUM_RREGS - 1:0],
  output evt_router_pkg::chan_t     rt_chan [`NUM_RREGS - 1:0]
);

  evt_router_pkg::ctr_t  ctr_routed;
  evt_router_pkg::ctr_t  ctr_dropped;
  evt_router_pkg::word_t rd_data;
  logic                  addr_ok;
  logic                  addr_ro;
  logic                  wr_en;
  logic [`NUM_RREGS - 1:0] key_sel;
  logic [`NUM_RREGS - 1:0] msk_sel;
  logic [`NUM_RREGS - 1:0] chn_sel;

  //--------------------------------------------------------------------
  // address decode and read mux
  //--------------------------------------------------------------------
  always_comb
  begin
    rd_data = '0;
    addr_ok = 1'b1;
    addr_ro = 1'b0;
    key_sel = '0;
    msk_sel = '0;
    chn_sel = '0;
    case (paddr)
      `REG_CTRL:      rd_data = evt_router_pkg::word_t'(enable);
      `REG_MP_KEY:    rd_data = mp_key;
      `REG_FMSK0:     rd_data = fmsk[0];
      `REG_FMSK1:     rd_data = fmsk[1];
      `REG_DROP_WAIT: rd_data = evt_router_pkg::word_t'(drop_wait);
      `REG_FSFT:
      begin
        // one byte lane per field
        for (int i = 0; i < `NUM_FIELDS; i++)
          rd_data[8 * i +: `SFT_BITS] = fsft[i];
      end
      `REG_CTR_ROUTED:
      begin
        rd_data = ctr_routed;
        addr_ro = 1'b1;
      end
      `REG_CTR_DROPPED:
      begin
        rd_data = ctr_dropped;
        addr_ro = 1'b1;
      end
      default:
      begin
        // routing table, three banks of NUM_RREGS words
        addr_ok = 1'b0;
        for (int i = 0; i < `NUM_RREGS; i++)
        begin
          if (paddr == evt_router_pkg::apb_addr_t'(`REG_RT_KEY + `REG_RT_STRIDE * i))
          begin
            key_sel[i] = 1'b1;
            rd_data    = rt_key[i];
            addr_ok    = 1'b1;
          end
          if (paddr == evt_router_pkg::apb_addr_t'(`REG_RT_MASK + `REG_RT_STRIDE * i))
          begin
            msk_sel[i] = 1'b1;
            rd_data    = rt_mask[i];
            addr_ok    = 1'b1;
          end
          if (paddr == evt_router_pkg::apb_addr_t'(`REG_RT_CHAN + `REG_RT_STRIDE * i))
          begin
            chn_sel[i] = 1'b1;
            rd_data    = evt_router_pkg::word_t'(rt_chan[i]);
            addr_ok    = 1'b1;
          end
        end
      end
    endcase
  end

  assign prdata  = rd_data;
  assign pready  = 1'b1;
  // error only in the access phase
  assign pslverr = psel && penable && (!addr_ok || (pwrite && addr_ro));
  assign wr_en   = psel && penable && pwrite && addr_ok && !addr_ro;

  //--------------------------------------------------------------------
  // configuration registers
  //--------------------------------------------------------------------
  always_ff @(posedge pl_clk0_buf_int or negedge arst_n)
  begin
    if (!arst_n)
    begin
      enable    <= 1'b0;
      mp_key    <= '0;
      drop_wait <= '0;
      for (int i = 0; i < `NUM_FIELDS; i++)
      begin
        fmsk[i] <= '0;
        fsft[i] <= '0;
      end
      for (int i = 0; i < `NUM_RREGS; i++)
      begin
        rt_key[i]  <= '0;
        rt_mask[i] <= '0;
        rt_chan[i] <= '0;
      end
    end
    else if (wr_en)
    begin
      case (paddr)
        `REG_CTRL:      enable    <= pwdata[0];
        `REG_MP_KEY:    mp_key    <= pwdata;
        `REG_FMSK0:     fmsk[0]   <= pwdata;
        `REG_FMSK1:     fmsk[1]   <= pwdata;
        `REG_DROP_WAIT: drop_wait <= pwdata[`WAIT_BITS - 1:0];
        `REG_FSFT:
        begin
          for (int i = 0; i < `NUM_FIELDS; i++)
            fsft[i] <= pwdata[8 * i +: `SFT_BITS];
        end
        default:
        begin
          for (int i = 0; i < `NUM_RREGS; i++)
          begin
            if (key_sel[i])
              rt_key[i] <= pwdata;
            if (msk_sel[i])
              rt_mask[i] <= pwdata;
            if (chn_sel[i])
              rt_chan[i] <= pwdata[$bits(evt_router_pkg::chan_t) - 1:0];
          end
        end
      endcase
    end
  end

  // packet counters
  always_ff @(posedge pl_clk0_buf_int or negedge arst_n)
  begin
    if (!arst_n)
    begin
      ctr_routed  <= '0;
      ctr_dropped <= '0;
    end
    else
    begin
      if (routed_cnt)
        ctr_routed <= ctr_routed + 1'b1;
      if (dropped_cnt)
        ctr_dropped <= ctr_dropped + 1'b1;
    end
  end

  // access phase must follow a setup phase
  apb_access_after_setup : assert property (
    @(posedge pl_clk0_buf_int) disable iff (!arst_n)
    penable |-> $past(psel && !penable));

endmodule

/* verilog/evt_router_defines.svh */
// widths, table sizes and register map of the event router
// all register offsets are APB byte addresses, word aligned
// chan fields assume NUM_CHANS is a power of two

`ifndef EVT_ROUTER_DEFINES_SVH
`define EVT_ROUTER_DEFINES_SVH

// datapath widths
`define EVT_BITS        32
`define PKT_BITS        32
`define APB_ADR_BITS    8

// sizes
`define NUM_CHANS       2
`define NUM_RREGS       4
`define NUM_FIELDS      2
`define SFT_BITS        5
`define WAIT_BITS       16

// register map
`define REG_CTRL        8'h00
`define REG_MP_KEY      8'h04
`define REG_FMSK0       8'h08
`define REG_FMSK1       8'h0C
`define REG_FSFT        8'h10
`define REG_DROP_WAIT   8'h14
`define REG_RT_KEY      8'h20
`define REG_RT_MASK     8'h30
`define REG_RT_CHAN     8'h40
`define REG_RT_STRIDE   4
`define REG_CTR_ROUTED  8'h50
`define REG_CTR_DROPPED 8'h54

`endif

/* verilog/evt_router_pkg.sv */
// shared types of the event router
// widths come from the defines header, so it must be compiled first

`include "evt_router_defines.svh"

package evt_router_pkg;

  // event and packet payloads
  typedef logic [`EVT_BITS - 1:0] evt_t;
  typedef logic [`PKT_BITS - 1:0] pkt_t;

  // APB side
  typedef logic [`APB_ADR_BITS - 1:0] apb_addr_t;
  typedef logic [31:0] word_t;

  // configuration fields
  typedef logic [`SFT_BITS - 1:0] sft_t;
  typedef logic [`WAIT_BITS - 1:0] wait_t;
  typedef logic [$clog2(`NUM_CHANS) - 1:0] chan_t;

  // diagnostic counters
  typedef logic [31:0] ctr_t;

  // router FSM
  typedef enum logic [1:0] {st_idle, st_hold, st_drop} rtr_state_e;

endpackage

/* verilog/evt_router_top.sv */
// event router top level, single clock domain
// APB configures the mapper and routing table, events in, packets out
// enable resets low, software must set it before events are routed

`timescale 1ns/10ps
`include "evt_router_defines.svh"

module evt_router_top
(
  input  logic                      pl_clk0_buf_int,
  input  logic                      arst_n,

  // APB slave
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  evt_router_pkg::apb_addr_t paddr,
  input  evt_router_pkg::word_t     pwdata,
  output evt_router_pkg::word_t     prdata,
  output logic                      pready,
  output logic                      pslverr,

  // sensor events
  input  evt_router_pkg::evt_t      evt_data,
  input  logic                      evt_vld,
  output logic                      evt_rdy,

  // output channels
  output evt_router_pkg::pkt_t      ch_data [`NUM_CHANS - 1:0],
  output logic [`NUM_CHANS - 1:0]   ch_vld,
  input  logic [`NUM_CHANS - 1:0]   ch_rdy
);

  // configuration from the register bank
  logic                  enable;
  evt_router_pkg::pkt_t  mp_key;
  evt_router_pkg::pkt_t  fmsk [`NUM_FIELDS - 1:0];
  evt_router_pkg::sft_t  fsft [`NUM_FIELDS - 1:0];
  evt_router_pkg::wait_t drop_wait;
  evt_router_pkg::pkt_t  rt_key  [`NUM_RREGS - 1:0];
  evt_router_pkg::pkt_t  rt_mask [`NUM_RREGS - 1:0];
  evt_router_pkg::chan_t rt_chan [`NUM_RREGS - 1:0];

  // assembler to router
  evt_router_pkg::pkt_t  pkt_data;
  logic                  pkt_vld;
  logic                  pkt_rdy;

  // router to counters
  logic                  routed_cnt;
  logic                  dropped_cnt;

  //--------------------------------------------------------------------
  // all local names match the submodule ports
  //--------------------------------------------------------------------
  evt_reg_bank u_reg_bank (.*);

  pkt_assembler u_assembler (.*);

  pkt_router u_router (.*);

endmodule

/* verilog/pkt_assembler.sv */
// maps sensor events into packet keys, one-entry output buffer
// events are accepted and discarded while enable is low
// evt_rdy stays low for the first cycle after reset

`timescale 1ns/10ps
`include "evt_router_defines.svh"

module pkt_assembler
(
  input  logic                  pl_clk0_buf_int,
  input  logic                  arst_n,

  // mapper configuration
  input  logic                  enable,
  input  evt_router_pkg::pkt_t  mp_key,
  input  evt_router_pkg::pkt_t  fmsk [`NUM_FIELDS - 1:0],
  input  evt_router_pkg::sft_t  fsft [`NUM_FIELDS - 1:0],

  // incoming events
  input  evt_router_pkg::evt_t  evt_data,
  input  logic                  evt_vld,
  output logic                  evt_rdy,

  // packets to the router
  output evt_router_pkg::pkt_t  pkt_data,
  output logic                  pkt_vld,
  input  logic                  pkt_rdy
);

  evt_router_pkg::pkt_t key;
  logic                 rst_done;
  logic                 evt_take;

  // key = mp_key | field0 | field1, each field masked then shifted
  always_comb
  begin
    key = mp_key;
    for (int i = 0; i < `NUM_FIELDS; i++)
      key = key | ((evt_router_pkg::pkt_t'(evt_data) & fmsk[i]) >> fsft[i]);
  end

  // free or emptying this cycle
  assign evt_rdy  = rst_done && (!enable || !pkt_vld || pkt_rdy);
  assign evt_take = evt_vld && evt_rdy && enable;

  always_ff @(posedge pl_clk0_buf_int or negedge arst_n)
  begin
    if (!arst_n)
    begin
      rst_done <= 1'b0;
      pkt_vld  <= 1'b0;
    end
    else
    begin
      rst_done <= 1'b1;
      if (evt_take)
        pkt_vld <= 1'b1;
      else if (pkt_rdy)
        pkt_vld <= 1'b0;
    end
  end

  // output buffer payload
  always_ff @(posedge pl_clk0_buf_int)
  begin
    if (evt_take)
      pkt_data <= key;
  end

  // held packet does not change under back-pressure
  pkt_hold_stable : assert property (
    @(posedge pl_clk0_buf_int) disable iff (!arst_n)
    pkt_vld && !pkt_rdy |=> pkt_vld && $stable(pkt_data));

endmodule

/* verilog/pkt_router.sv */
// routes packet keys to the output channels by key/mask table
// lowest matching entry wins, no match means the packet is dropped
// a blocked packet waits at most drop_wait cycles, then is dropped
// one packet in flight inside the router, one per channel register

`timescale 1ns/10ps
`include "evt_router_defines.svh"

module pkt_router
(
  input  logic                   pl_clk0_buf_int,
  input  logic                   arst_n,

  // configuration
  input  evt_router_pkg::wait_t  drop_wait,
  input  evt_router_pkg::pkt_t   rt_key  [`NUM_RREGS - 1:0],
  input  evt_router_pkg::pkt_t   rt_mask [`NUM_RREGS - 1:0],
  input  evt_router_pkg::chan_t  rt_chan [`NUM_RREGS - 1:0],

  // packets from the assembler
  input  evt_router_pkg::pkt_t   pkt_data,
  input  logic                   pkt_vld,
  output logic                   pkt_rdy,

  // channel outputs
  output evt_router_pkg::pkt_t   ch_data [`NUM_CHANS - 1:0],
  output logic [`NUM_CHANS - 1:0] ch_vld,
  input  logic [`NUM_CHANS - 1:0] ch_rdy,

  // counter pulses
  output logic                   routed_cnt,
  output logic                   dropped_cnt
);

  evt_router_pkg::rtr_state_e state;
  evt_router_pkg::rtr_state_e nxt_state;
  evt_router_pkg::pkt_t       pend_data;
  evt_router_pkg::wait_t      wait_ctr;
  evt_router_pkg::chan_t      tgt;
  logic                       hit;
  logic                       tgt_free;
  logic                       load;

  //--------------------------------------------------------------------
  // table lookup on the pending packet
  //--------------------------------------------------------------------
  always_comb
  begin
    hit = 1'b0;
    tgt = '0;
    // walk down so the lowest entry is written last
    for (int i = `NUM_RREGS - 1; i >= 0; i--)
    begin
      if ((pend_data & rt_mask[i]) == rt_key[i])
      begin
        hit = 1'b1;
        tgt = rt_chan[i];
      end
    end
  end

  assign tgt_free    = !ch_vld[tgt] || ch_rdy[tgt];
  assign load        = (state == evt_router_pkg::st_hold) && hit && tgt_free;
  assign pkt_rdy     = (state == evt_router_pkg::st_idle);
  assign routed_cnt  = load;
  assign dropped_cnt = (state == evt_router_pkg::st_drop);

  //--------------------------------------------------------------------
  // drop-on-wait FSM
  //--------------------------------------------------------------------
  always_comb
  begin
    nxt_state = state;
    case (state)
      evt_router_pkg::st_idle:
        if (pkt_vld)
          nxt_state = evt_router_pkg::st_hold;
      evt_router_pkg::st_hold:
        if (load)
          nxt_state = evt_router_pkg::st_idle;
        else if (!hit || (wait_ctr >= drop_wait))
          nxt_state = evt_router_pkg::st_drop;
      default:
        nxt_state = evt_router_pkg::st_idle;
    endcase
  end

  always_ff @(posedge pl_clk0_buf_int or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state    <= evt_router_pkg::st_idle;
      wait_ctr <= '0;
    end
    else
    begin
      state <= nxt_state;
      // count blocked cycles in hold
      if (state == evt_router_pkg::st_hold)
        wait_ctr <= wait_ctr + 1'b1;
      else
        wait_ctr <= '0;
    end
  end

  // packet under routing
  always_ff @(posedge pl_clk0_buf_int)
  begin
    if (pkt_vld && pkt_rdy)
      pend_data <= pkt_data;
  end

  //--------------------------------------------------------------------
  // channel output registers
  //--------------------------------------------------------------------
  always_ff @(posedge pl_clk0_buf_int or negedge arst_n)
  begin
    if (!arst_n)
      ch_vld <= '0;
    else
    begin
      for (int c = 0; c < `NUM_CHANS; c++)
      begin
        if (load && (tgt == evt_router_pkg::chan_t'(c)))
          ch_vld[c] <= 1'b1;
        else if (ch_rdy[c])
          ch_vld[c] <= 1'b0;
      end
    end
  end

  always_ff @(posedge pl_clk0_buf_int)
  begin
    for (int c = 0; c < `NUM_CHANS; c++)
      if (load && (tgt == evt_router_pkg::chan_t'(c)))
        ch_data[c] <= pend_data;
  end

  // a waiting channel keeps its packet
  for (genvar c = 0; c < `NUM_CHANS; c++)
  begin : g_chk
    ch_hold_stable : assert property (
      @(posedge pl_clk0_buf_int) disable iff (!arst_n)
      ch_vld[c] && !ch_rdy[c] |=> ch_vld[c] && $stable(ch_data[c]));
  end

endmodule
